/* include/tmds_defs.svh */
`ifndef TMDS_DEFS_SVH
`define TMDS_DEFS_SVH

// width of one TMDS character
`define TMDS_SYM_W 10

// cycles the decoder holds data back to see coming periods
`define TMDS_LOOKAHEAD 2

// leading and trailing guard band length
`define TMDS_GUARD_LEN 2

// control period characters, indexed by {c1, c0}
`define TMDS_CTRL_00 10'b1101010100
`define TMDS_CTRL_01 10'b0010101011
`define TMDS_CTRL_10 10'b0101010100
`define TMDS_CTRL_11 10'b1010101011

// video leading guard band, channels 0/2 and channel 1
`define TMDS_VGUARD_A 10'b1011001100
`define TMDS_VGUARD_B 10'b0100110011

// island guard band on channels 1 and 2
`define TMDS_DGUARD_B 10'b0100110011

`endif

/* logic/tmds_pkg.sv */
`default_nettype none

package tmds_pkg;

    // what a lane transmits in a given pixel clock
    typedef enum logic [2:0] {
        period_control      = 3'd0,
        period_video        = 3'd1,
        period_video_guard  = 3'd2,
        period_island       = 3'd3,
        period_island_guard = 3'd4
    } tmds_period_e;

    // island view of the lane payload byte
    typedef struct packed {
        logic [1:0] spare;
        // control pair, channel 0 carries {vsync, hsync}
        logic [1:0] ctl;
        logic [3:0] nibble;
    } tmds_island_s;

    // pixel byte during video, island fields otherwise
    typedef union packed {
        logic [7:0]   pixel;
        tmds_island_s island;
    } tmds_payload_u;

endpackage

`default_nettype wire

/* logic/tmds_lane_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tmds_defs.svh"

interface tmds_lane_if import tmds_pkg::*; ();

    tmds_period_e              period;
    tmds_payload_u             payload;
    logic [1:0]                ctl;
    // transition-minimised video character
    logic [`TMDS_SYM_W-1:0]    video_sym;

    modport decode (
        output period, payload, ctl
    );

    modport encode (
        input  period, payload,
        output video_sym
    );

    modport select (
        input period, payload, ctl, video_sym
    );

endinterface

`default_nettype wire

/* logic/tmds_period_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tmds_defs.svh"

module tmds_period_decode import tmds_pkg::*; (
    input  logic        pxl_clk,
    input  logic        rst_n,
    input  logic [23:0] rgb,
    input  logic        video_de,
    input  logic        hsync,
    input  logic        vsync,
    input  logic [3:0]  ctl,
    input  logic        island_de,
    input  logic [11:0] island_data,
    tmds_lane_if.decode lane0,
    tmds_lane_if.decode lane1,
    tmds_lane_if.decode lane2
);

    localparam int LA    = `TMDS_LOOKAHEAD;
    localparam int RUN_W = $clog2(`TMDS_GUARD_LEN + 1);

    // index k holds the sample taken k cycles ago
    logic [LA:1]      vde_q;
    logic [LA:1]      ide_q;
    logic [23:0]      rgb_q [1:LA];
    logic [5:0]       ctl_q [1:LA];
    logic [11:0]      nib_q [1:LA];

    // island samples already seen in the current run
    logic [RUN_W-1:0] run_cnt;

    // bit LA is the sample being classified, bit 0 the live input
    logic [LA:0]      vde_win;
    logic [LA:0]      ide_win;
    tmds_period_e     period;

    function automatic tmds_payload_u lane_payload(
        input tmds_period_e p,
        input logic [7:0]   pix,
        input logic [1:0]   c,
        input logic [3:0]   nib
    );
        tmds_payload_u pl;
        if (p == period_video) begin
            pl.pixel = pix;
        end else begin
            pl.island.spare  = 2'b00;
            pl.island.ctl    = c;
            pl.island.nibble = nib;
        end
        return pl;
    endfunction

    assign vde_win = {vde_q, video_de};
    assign ide_win = {ide_q, island_de};

    always_ff @(posedge pxl_clk or negedge rst_n) begin
        if (!rst_n) begin
            vde_q <= '0;
            ide_q <= '0;
            for (int k = 1; k <= LA; k++) begin
                rgb_q[k] <= '0;
                ctl_q[k] <= '0;
                nib_q[k] <= '0;
            end
        end else begin
            vde_q    <= vde_win[LA-1:0];
            ide_q    <= ide_win[LA-1:0];
            rgb_q[1] <= rgb;
            // channel pairs packed as {ch2, ch1, ch0}
            ctl_q[1] <= {ctl, vsync, hsync};
            nib_q[1] <= island_data;
            for (int k = 2; k <= LA; k++) begin
                rgb_q[k] <= rgb_q[k-1];
                ctl_q[k] <= ctl_q[k-1];
                nib_q[k] <= nib_q[k-1];
            end
        end
    end

    // saturates once past the leading guard
    always_ff @(posedge pxl_clk or negedge rst_n) begin
        if (!rst_n) begin
            run_cnt <= '0;
        end else if (!ide_win[LA]) begin
            run_cnt <= '0;
        end else if (run_cnt != RUN_W'(`TMDS_GUARD_LEN)) begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    always_comb begin
        if (vde_win[LA]) begin
            period = period_video;
        end else if (|vde_win[LA-1:0]) begin
            period = period_video_guard;
        end else if (ide_win[LA]) begin
            // leading guard by run count, trailing guard by lookahead
            if (run_cnt < RUN_W'(`TMDS_GUARD_LEN) || !(&ide_win[LA-1:0])) begin
                period = period_island_guard;
            end else begin
                period = period_island;
            end
        end else begin
            period = period_control;
        end
    end

    // blue, green, red on channels 0, 1, 2
    assign lane0.period  = period;
    assign lane0.ctl     = ctl_q[LA][1:0];
    assign lane0.payload = lane_payload(period, rgb_q[LA][7:0], ctl_q[LA][1:0],
                                        nib_q[LA][3:0]);

    assign lane1.period  = period;
    assign lane1.ctl     = ctl_q[LA][3:2];
    assign lane1.payload = lane_payload(period, rgb_q[LA][15:8], ctl_q[LA][3:2],
                                        nib_q[LA][7:4]);

    assign lane2.period  = period;
    assign lane2.ctl     = ctl_q[LA][5:4];
    assign lane2.payload = lane_payload(period, rgb_q[LA][23:16], ctl_q[LA][5:4],
                                        nib_q[LA][11:8]);

endmodule

`default_nettype wire

/* logic/tmds_video_encode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tmds_defs.svh"

module tmds_video_encode import tmds_pkg::*; #(
    parameter int CHANNEL = 0
) (
    input  logic        pxl_clk,
    input  logic        rst_n,
    tmds_lane_if.encode lane
);

    logic [7:0]              pix;
    logic [3:0]              n1_d;
    logic                    use_xnor;
    logic [8:0]              q_m;
    logic [3:0]              n1_q;
    logic [3:0]              n0_q;
    // ones minus zeros of q_m[7:0]
    logic signed [4:0]       bal;
    logic signed [4:0]       disp;
    logic signed [4:0]       disp_next;
    logic [`TMDS_SYM_W-1:0]  q_out;

    if (CHANNEL < 0 || CHANNEL > 2) begin : g_bad_channel
        $error("tmds_video_encode: CHANNEL %0d out of range", CHANNEL);
    end

    assign pix = lane.payload.pixel;

    // stage 1, transition minimising
    always_comb begin
        n1_d = '0;
        for (int i = 0; i < 8; i++) begin
            n1_d = n1_d + 4'(pix[i]);
        end
        use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !pix[0]);

        q_m[0] = pix[0];
        for (int i = 1; i < 8; i++) begin
            if (use_xnor) begin
                q_m[i] = ~(q_m[i-1] ^ pix[i]);
            end else begin
                q_m[i] = q_m[i-1] ^ pix[i];
            end
        end
        // set when the XOR chain was used
        q_m[8] = ~use_xnor;

        n1_q = '0;
        for (int i = 0; i < 8; i++) begin
            n1_q = n1_q + 4'(q_m[i]);
        end
        n0_q = 4'd8 - n1_q;
        bal  = $signed({1'b0, n1_q}) - $signed({1'b0, n0_q});
    end

    // stage 2, DC balancing per HDMI 5.4.4.1
    always_comb begin
        if (disp == 5'sd0 || n1_q == n0_q) begin
            q_out[9] = ~q_m[8];
            q_out[8] = q_m[8];
            if (q_m[8]) begin
                q_out[7:0] = q_m[7:0];
                disp_next  = disp + bal;
            end else begin
                q_out[7:0] = ~q_m[7:0];
                disp_next  = disp - bal;
            end
        end else if ((disp > 5'sd0 && n1_q > n0_q) || (disp < 5'sd0 && n0_q > n1_q)) begin
            // invert to pull the count back toward zero
            q_out     = {1'b1, q_m[8], ~q_m[7:0]};
            disp_next = disp + (q_m[8] ? 5'sd2 : 5'sd0) - bal;
        end else begin
            q_out     = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disp - (q_m[8] ? 5'sd0 : 5'sd2) + bal;
        end
    end

    // counter restarts at zero outside video
    always_ff @(posedge pxl_clk or negedge rst_n) begin
        if (!rst_n) begin
            disp <= '0;
        end else if (lane.period == period_video) begin
            disp <= disp_next;
        end else begin
            disp <= '0;
        end
    end

    assign lane.video_sym = q_out;

endmodule

`default_nettype wire

/* logic/tmds_symbol_select.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tmds_defs.svh"

module tmds_symbol_select import tmds_pkg::*; #(
    parameter int CHANNEL = 0
) (
    input  logic                   pxl_clk,
    input  logic                   rst_n,
    tmds_lane_if.select            lane,
    output logic [`TMDS_SYM_W-1:0] tmds
);

    logic [`TMDS_SYM_W-1:0] ctrl_sym;
    logic [`TMDS_SYM_W-1:0] terc4_sym;
    logic [`TMDS_SYM_W-1:0] vguard_sym;
    logic [`TMDS_SYM_W-1:0] dguard_sym;

    // HDMI 5.4.2 control characters
    function automatic logic [`TMDS_SYM_W-1:0] ctrl_code(input logic [1:0] c);
        case (c)
            2'b00:   return `TMDS_CTRL_00;
            2'b01:   return `TMDS_CTRL_01;
            2'b10:   return `TMDS_CTRL_10;
            default: return `TMDS_CTRL_11;
        endcase
    endfunction

    // HDMI 5.4.3 TERC4 table
    function automatic logic [`TMDS_SYM_W-1:0] terc4_code(input logic [3:0] nib);
        case (nib)
            4'h0:    return 10'b1010011100;
            4'h1:    return 10'b1001100011;
            4'h2:    return 10'b1011100100;
            4'h3:    return 10'b1011100010;
            4'h4:    return 10'b0101110001;
            4'h5:    return 10'b0100011110;
            4'h6:    return 10'b0110001110;
            4'h7:    return 10'b0100111100;
            4'h8:    return 10'b1011001100;
            4'h9:    return 10'b0100111001;
            4'ha:    return 10'b0110011100;
            4'hb:    return 10'b1011000110;
            4'hc:    return 10'b1010001110;
            4'hd:    return 10'b1001110001;
            4'he:    return 10'b0101100011;
            default: return 10'b1011000011;
        endcase
    endfunction

    always_comb begin
        ctrl_sym  = ctrl_code(lane.ctl);
        terc4_sym = terc4_code(lane.payload.island.nibble);

        if (CHANNEL == 1) begin
            vguard_sym = `TMDS_VGUARD_B;
        end else begin
            vguard_sym = `TMDS_VGUARD_A;
        end

        // channel 0 guard still carries the syncs
        if (CHANNEL == 0) begin
            dguard_sym = terc4_code({2'b11, lane.payload.island.ctl});
        end else begin
            dguard_sym = `TMDS_DGUARD_B;
        end
    end

    always_ff @(posedge pxl_clk or negedge rst_n) begin
        if (!rst_n) begin
            tmds <= `TMDS_CTRL_00;
        end else begin
            case (lane.period)
                period_video:        tmds <= lane.video_sym;
                period_video_guard:  tmds <= vguard_sym;
                period_island:       tmds <= terc4_sym;
                period_island_guard: tmds <= dguard_sym;
                default:             tmds <= ctrl_sym;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/hdmi_tmds_tx.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tmds_defs.svh"

module hdmi_tmds_tx (
    input  logic                   pxl_clk,
    input  logic                   rst_n,
    input  logic [23:0]            rgb,
    input  logic                   video_de,
    input  logic                   hsync,
    input  logic                   vsync,
    input  logic [3:0]             ctl,
    input  logic                   island_de,
    input  logic [11:0]            island_data,
    output logic [`TMDS_SYM_W-1:0] tmds0,
    output logic [`TMDS_SYM_W-1:0] tmds1,
    output logic [`TMDS_SYM_W-1:0] tmds2
);

    tmds_lane_if lane0_if ();
    tmds_lane_if lane1_if ();
    tmds_lane_if lane2_if ();

    // one classifier shared by all three channels
    tmds_period_decode u_decode (
        .pxl_clk     (pxl_clk),
        .rst_n       (rst_n),
        .rgb         (rgb),
        .video_de    (video_de),
        .hsync       (hsync),
        .vsync       (vsync),
        .ctl         (ctl),
        .island_de   (island_de),
        .island_data (island_data),
        .lane0       (lane0_if),
        .lane1       (lane1_if),
        .lane2       (lane2_if)
    );

    tmds_video_encode #(.CHANNEL(0)) u_encode0 (
        .pxl_clk (pxl_clk),
        .rst_n   (rst_n),
        .lane    (lane0_if)
    );

    tmds_video_encode #(.CHANNEL(1)) u_encode1 (
        .pxl_clk (pxl_clk),
        .rst_n   (rst_n),
        .lane    (lane1_if)
    );

    tmds_video_encode #(.CHANNEL(2)) u_encode2 (
        .pxl_clk (pxl_clk),
        .rst_n   (rst_n),
        .lane    (lane2_if)
    );

    tmds_symbol_select #(.CHANNEL(0)) u_select0 (
        .pxl_clk (pxl_clk),
        .rst_n   (rst_n),
        .lane    (lane0_if),
        .tmds    (tmds0)
    );

    tmds_symbol_select #(.CHANNEL(1)) u_select1 (
        .pxl_clk (pxl_clk),
        .rst_n   (rst_n),
        .lane    (lane1_if),
        .tmds    (tmds1)
    );

    tmds_symbol_select #(.CHANNEL(2)) u_select2 (
        .pxl_clk (pxl_clk),
        .rst_n   (rst_n),
        .lane    (lane2_if),
        .tmds    (tmds2)
    );

endmodule

`default_nettype wire

/* dv/tmds_encoder_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module tmds_encoder_properties import tmds_pkg::*; (
    input logic              pxl_clk,
    input logic              rst_n,
    input tmds_period_e      period,
    input logic signed [4:0] disp,
    input logic [9:0]        video_sym
);

    // count of failed assertions
    int unsigned fail_cnt = 0;

    // a TMDS stream never drifts more than ten bits off balance
    a_disp_range: assert property (@(posedge pxl_clk) disable iff (!rst_n)
        disp >= -5'sd10 && disp <= 5'sd10)
        else begin
            fail_cnt++;
            $error("disparity %0d outside +-10", disp);
        end

    // first video character after a gap takes the zero-disparity branch
    a_disp_cleared: assert property (@(posedge pxl_clk) disable iff (!rst_n)
        period != period_video |=> disp == 5'sd0 &&
            (period != period_video || video_sym[9] != video_sym[8]))
        else begin
            fail_cnt++;
            $error("video restart after a non-video cycle with disparity %0d", disp);
        end

    a_sym_known: assert property (@(posedge pxl_clk) disable iff (!rst_n)
        !$isunknown(video_sym))
        else begin
            fail_cnt++;
            $error("video character has unknown bits");
        end

endmodule

bind tmds_video_encode tmds_encoder_properties u_encoder_props (
    .pxl_clk   (pxl_clk),
    .rst_n     (rst_n),
    .period    (lane.period),
    .disp      (disp),
    .video_sym (lane.video_sym)
);

`default_nettype wire

/* dv/hdmi_tmds_tx_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tmds_defs.svh"

module hdmi_tmds_tx_tb import tmds_pkg::*; ();

    localparam int MAX_CYC = 400;
    localparam int MARGIN  = 50;

    // HDMI TERC4 characters, nibble 0 first
    localparam logic [9:0] TERC4_TAB [16] = '{
        10'b1010011100, 10'b1001100011, 10'b1011100100, 10'b1011100010,
        10'b0101110001, 10'b0100011110, 10'b0110001110, 10'b0100111100,
        10'b1011001100, 10'b0100111001, 10'b0110011100, 10'b1011000110,
        10'b1010001110, 10'b1001110001, 10'b0101100011, 10'b1011000011
    };
    localparam logic [9:0] CTRL_TAB [4] = '{
        `TMDS_CTRL_00, `TMDS_CTRL_01, `TMDS_CTRL_10, `TMDS_CTRL_11
    };

    logic        pxl_clk;
    logic        rst_n;
    logic [23:0] rgb;
    logic        video_de;
    logic        hsync;
    logic        vsync;
    logic [3:0]  ctl;
    logic        island_de;
    logic [11:0] island_data;
    logic [9:0]  tmds0;
    logic [9:0]  tmds1;
    logic [9:0]  tmds2;

    // scripted input cycles
    logic [23:0] c_rgb  [MAX_CYC];
    logic        c_vde  [MAX_CYC];
    logic        c_ide  [MAX_CYC];
    logic        c_hs   [MAX_CYC];
    logic        c_vs   [MAX_CYC];
    logic [3:0]  c_ctl  [MAX_CYC];
    logic [11:0] c_idat [MAX_CYC];
    logic        c_rst  [MAX_CYC];
    logic [9:0]  exp_sym [MAX_CYC][3];
    logic        exp_vid [MAX_CYC];
    string       seg_name [8];
    int          seg_end  [8];

    int n_cyc       = 0;
    int n_seg       = 0;
    int cycle_cnt   = 0;
    int chk_cnt     = 0;
    int err_cnt     = 0;
    bit check_done  = 1'b0;

    hdmi_tmds_tx u_hdmi_tmds_tx (
        .pxl_clk     (pxl_clk),
        .rst_n       (rst_n),
        .rgb         (rgb),
        .video_de    (video_de),
        .hsync       (hsync),
        .vsync       (vsync),
        .ctl         (ctl),
        .island_de   (island_de),
        .island_data (island_data),
        .tmds0       (tmds0),
        .tmds1       (tmds1),
        .tmds2       (tmds2)
    );

    initial pxl_clk = 1'b0;
    always #10 pxl_clk = ~pxl_clk;

    always @(posedge pxl_clk) cycle_cnt <= cycle_cnt + 1;

    // reset cycles carry idle inputs
    task automatic push_run(input logic vde, input logic ide, input logic rst, input int len);
        logic [63:0] r;
        for (int n = 0; n < len; n++) begin
            r = {$urandom, $urandom};
            if (rst) begin
                r = '0;
            end
            c_rgb[n_cyc]  = r[23:0];
            c_hs[n_cyc]   = r[24];
            c_vs[n_cyc]   = r[25];
            c_ctl[n_cyc]  = r[29:26];
            c_idat[n_cyc] = r[41:30];
            c_vde[n_cyc]  = vde & !rst;
            c_ide[n_cyc]  = ide & !rst;
            c_rst[n_cyc]  = rst;
            n_cyc++;
        end
    endtask

    task automatic close_test(input string name);
        seg_name[n_seg] = name;
        seg_end[n_seg]  = n_cyc - 1;
        n_seg++;
    endtask

    task automatic build_script();
        push_run(0, 0, 1, 1);
        // each channel walks through all four control pairs
        for (int k = 0; k < 16; k++) begin
            push_run(0, 0, 0, 1);
            {c_ctl[n_cyc-1], c_vs[n_cyc-1], c_hs[n_cyc-1]} = {k[1:0], k[3:2], k[1:0]};
        end
        close_test("control period");
        push_run(0, 0, 0, 4);
        push_run(1, 0, 0, 3);
        push_run(0, 0, 0, 2);
        push_run(1, 0, 0, 2);
        push_run(0, 0, 0, 1);
        push_run(1, 0, 0, 4);
        push_run(0, 0, 0, 3);
        close_test("video guard");
        for (int l = 0; l < 3; l++) begin
            push_run(1, 0, 0, 40);
            push_run(0, 0, 0, 6);
        end
        close_test("video coding");
        push_run(0, 1, 0, 8);
        push_run(0, 0, 0, 3);
        push_run(0, 1, 0, 5);
        push_run(0, 0, 0, 3);
        push_run(0, 1, 0, 3);
        push_run(0, 0, 0, 4);
        // video overlapping an island run
        push_run(0, 1, 0, 4);
        push_run(1, 1, 0, 3);
        push_run(0, 1, 0, 4);
        push_run(0, 0, 0, 4);
        close_test("data islands");
        push_run(1, 0, 0, 10);
        push_run(1, 0, 1, 2);
        push_run(1, 0, 0, 12);
        push_run(0, 0, 0, 6);
        close_test("reset mid-line");
    endtask

    function automatic logic flag_at(input int j, input bit island);
        if (j < 0 || j >= n_cyc) begin
            return 1'b0;
        end
        return island ? c_ide[j] : c_vde[j];
    endfunction

    function automatic tmds_period_e period_of(input int j);
        if (flag_at(j, 0)) begin
            return period_video;
        end
        if (flag_at(j + 1, 0) || flag_at(j + 2, 0)) begin
            return period_video_guard;
        end
        if (!flag_at(j, 1)) begin
            return period_control;
        end
        // first two or last two cycles of the run
        if (!(flag_at(j - 1, 1) && flag_at(j - 2, 1)) ||
            !(flag_at(j + 1, 1) && flag_at(j + 2, 1))) begin
            return period_island_guard;
        end
        return period_island;
    endfunction

    function automatic logic [9:0] encode_video(input logic [7:0] d, inout int cnt);
        logic [8:0] qm;
        logic       use_xnor;
        int         ones;
        int         zeros;
        use_xnor = ($countones(d) > 4) || ($countones(d) == 4 && d[0] == 1'b0);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = use_xnor ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = !use_xnor;
        ones  = $countones(qm[7:0]);
        zeros = 8 - ones;
        if (cnt == 0 || ones == zeros) begin
            cnt = qm[8] ? cnt + ones - zeros : cnt + zeros - ones;
            return {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
        end
        if ((cnt > 0 && ones > zeros) || (cnt < 0 && zeros > ones)) begin
            cnt = cnt + (qm[8] ? 2 : 0) + zeros - ones;
            return {1'b1, qm[8], ~qm[7:0]};
        end
        cnt = cnt - (qm[8] ? 0 : 2) + ones - zeros;
        return {1'b0, qm[8], qm[7:0]};
    endfunction

    // receiver side of the video code
    function automatic logic [7:0] decode_video(input logic [9:0] s);
        logic [7:0] w;
        logic [7:0] d;
        w    = s[9] ? ~s[7:0] : s[7:0];
        d[0] = w[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = s[8] ? (w[i] ^ w[i-1]) : ~(w[i] ^ w[i-1]);
        end
        return d;
    endfunction

    function automatic logic [9:0] expected_sym(input int j, input int ch, inout int cnt);
        tmds_period_e p;
        logic [1:0]   pair;
        logic [3:0]   nib;
        p   = period_of(j);
        nib = c_idat[j][4*ch +: 4];
        case (ch)
            0:       pair = {c_vs[j], c_hs[j]};
            1:       pair = c_ctl[j][1:0];
            default: pair = c_ctl[j][3:2];
        endcase
        if (p != period_video) begin
            cnt = 0;
        end
        case (p)
            period_video:        return encode_video(c_rgb[j][8*ch +: 8], cnt);
            period_video_guard:  return (ch == 1) ? `TMDS_VGUARD_B : `TMDS_VGUARD_A;
            period_island:       return TERC4_TAB[nib];
            period_island_guard: return (ch == 0) ? TERC4_TAB[{2'b11, pair}] : `TMDS_DGUARD_B;
            default:             return CTRL_TAB[pair];
        endcase
    endfunction

    task automatic compute_expected();
        int disp [3];
        bit flushed;
        disp = '{0, 0, 0};
        for (int j = 0; j < n_cyc; j++) begin
            // still in the pipeline when a reset hits
            flushed = 1'b0;
            for (int k = j + 1; k <= j + 3 && k < n_cyc; k++) begin
                if (c_rst[k] && !c_rst[j]) begin
                    flushed = 1'b1;
                end
            end
            exp_vid[j] = (period_of(j) == period_video) && !flushed;
            for (int ch = 0; ch < 3; ch++) begin
                exp_sym[j][ch] = expected_sym(j, ch, disp[ch]);
                if (flushed) begin
                    exp_sym[j][ch] = `TMDS_CTRL_00;
                end
            end
        end
    endtask

    initial begin : main
        int afail;
        void'($urandom(32'h9ef988a2));
        rst_n       = 1'b0;
        rgb         = '0;
        video_de    = 1'b0;
        hsync       = 1'b0;
        vsync       = 1'b0;
        ctl         = '0;
        island_de   = 1'b0;
        island_data = '0;
        build_script();
        compute_expected();
        for (int i = 0; i < n_cyc; i++) begin
            @(posedge pxl_clk);
            #2;
            rst_n       = !c_rst[i];
            rgb         = c_rgb[i];
            video_de    = c_vde[i];
            hsync       = c_hs[i];
            vsync       = c_vs[i];
            ctl         = c_ctl[i];
            island_de   = c_ide[i];
            island_data = c_idat[i];
        end
        wait (check_done);
        afail = u_hdmi_tmds_tx.u_encode0.u_encoder_props.fail_cnt
              + u_hdmi_tmds_tx.u_encode1.u_encoder_props.fail_cnt
              + u_hdmi_tmds_tx.u_encode2.u_encoder_props.fail_cnt;
        $display("checks %0d, mismatches %0d, assertion failures %0d", chk_cnt, err_cnt, afail);
        if (err_cnt == 0 && afail == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // character for input cycle j appears three clocks later
    initial begin : compare
        logic [9:0] act [3];
        int seg;
        int seg_chk;
        int seg_err;
        seg     = 0;
        seg_chk = 0;
        seg_err = 0;
        repeat (3) @(posedge pxl_clk);
        for (int j = 0; j < n_cyc; j++) begin
            @(posedge pxl_clk);
            @(negedge pxl_clk);
            act = '{tmds0, tmds1, tmds2};
            for (int ch = 0; ch < 3; ch++) begin
                chk_cnt++;
                seg_chk++;
                if (act[ch] !== exp_sym[j][ch]) begin
                    $display("Mismatch at %0t: cycle %0d channel %0d expected %b actual %b",
                             $time, j, ch, exp_sym[j][ch], act[ch]);
                    err_cnt++;
                    seg_err++;
                end
                if (exp_vid[j] && decode_video(act[ch]) !== c_rgb[j][8*ch +: 8]) begin
                    $display("Mismatch at %0t: cycle %0d channel %0d decodes to %h, pixel %h",
                             $time, j, ch, decode_video(act[ch]), c_rgb[j][8*ch +: 8]);
                    err_cnt++;
                    seg_err++;
                end
            end
            if (j == seg_end[seg]) begin
                $display("test %0d (%s): %0d checks, %0d errors",
                         seg + 1, seg_name[seg], seg_chk, seg_err);
                seg++;
                seg_chk = 0;
                seg_err = 0;
            end
        end
        check_done = 1'b1;
    end

    initial begin : watchdog
        wait (n_cyc > 0 && cycle_cnt >= n_cyc + MARGIN);
        $display("timeout: outputs still unchecked after %0d clock cycles", cycle_cnt);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* hdmi_tmds_tx.f */
+incdir+include
logic/tmds_pkg.sv
logic/tmds_lane_if.sv
logic/tmds_period_decode.sv
logic/tmds_video_encode.sv
logic/tmds_symbol_select.sv
logic/hdmi_tmds_tx.sv
dv/tmds_encoder_properties.sv
dv/hdmi_tmds_tx_tb.sv
